// ==== tb.f ====
core_pkg.sv
reg_file.sv
int_decode.sv
int_execute.sv
int_result.sv
int_core.sv
tb_int_core.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_int_core -f tb.f

# Nonzero exit status on $fatal
./obj_dir/Vtb_int_core

// ==== tb_int_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_int_core;

    localparam int CLK_PERIOD  = 40;
    localparam int NUM_INSTR   = 400;
    // Generous bound of 40 cycles per instruction
    localparam int TIMEOUT_NS  = NUM_INSTR * 40 * CLK_PERIOD;
    // At most three results are still in flight when the stream ends
    localparam int DRAIN_LIMIT = 100;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic        instr_ready;
    logic [31:0] instr;
    logic        result_valid;
    logic        result_ready;
    logic [4:0]  result_rd;
    logic [31:0] result_data;

    integer      seed;
    logic [31:0] model_regs [32];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    int          n_kept;
    int          n_results;
    int          n_sent;
    int          drain_cycles;
    logic        held_valid;
    logic [4:0]  held_rd;
    logic [31:0] held_data;
    logic [31:0] next_word;

    int_core #(.NUM_REGS(32)) int_core_i (
        .clk(clk), .rst_n(rst_n),
        .instr_valid(instr_valid), .instr_ready(instr_ready), .instr(instr),
        .result_valid(result_valid), .result_ready(result_ready),
        .result_rd(result_rd), .result_data(result_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the pipeline did not retire the instruction stream in time");
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////////////////////////
    // Reporting and random helpers
    ////////////////////////////////////////////////////////////

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("Mismatch %s: expected 0x%08h, actual 0x%08h",
                                      name, expected, actual));
        end
    endtask

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    // Small pool, x0 included, so dependencies are dense
    function automatic logic [4:0] pick_reg();
        return 5'(rand32() % 32'd6);
    endfunction

    function automatic logic [31:0] gen_instr();
        logic [31:0] sel;
        logic [31:0] fld;
        logic [31:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [6:0]  f7;
        logic [6:0]  bad_opc;
        sel = rand32() % 32'd100;
        fld = rand32();
        imm = rand32();
        rd  = pick_reg();
        rs1 = pick_reg();
        rs2 = pick_reg();
        // Alternate funct7 only for ADD/SUB and SRL/SRA
        f7  = (fld[3] && (fld[2:0] == 3'd0 || fld[2:0] == 3'd5)) ? 7'b0100000 : 7'b0;
        if (sel < 32'd5) begin
            case (fld[6:4])
                3'd0:    bad_opc = 7'b0000011;
                3'd1:    bad_opc = 7'b0100011;
                3'd2:    bad_opc = 7'b1100011;
                3'd3:    bad_opc = 7'b1101111;
                3'd4:    bad_opc = 7'b1100111;
                3'd5:    bad_opc = 7'b0010111;
                3'd6:    bad_opc = 7'b1110011;
                default: bad_opc = 7'b0001111;
            endcase
            return {imm[31:7], bad_opc};
        end else if (sel < 32'd45) begin
            return {f7, rs2, rs1, fld[2:0], rd, 7'b0110011};
        end else if (sel < 32'd90) begin
            // Shift immediates carry funct7 in imm[11:5]
            if (fld[2:0] == 3'd1 || fld[2:0] == 3'd5) begin
                imm[11:5] = f7;
            end
            return {imm[11:0], rs1, fld[2:0], rd, 7'b0010011};
        end else begin
            return {imm[31:12], rd, 7'b0110111};
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [63:0] ext;
        logic [4:0]  sh;
        logic        lt_u;
        logic        lt_s;
        sh   = b[4:0];
        // Fill with the sign only for SRA
        ext  = {{32{alt & a[31]}}, a} >> sh;
        lt_u = a < b;
        // Signs differ, so the negative one is smaller
        lt_s = (a[31] != b[31]) ? a[31] : lt_u;
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return {31'b0, lt_s};
            3'd3:    return {31'b0, lt_u};
            3'd4:    return a ^ b;
            3'd5:    return ext[31:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic model_accept(input logic [31:0] w);
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] val;
        logic        kept;
        rd   = w[11:7];
        a    = model_regs[w[19:15]];
        kept = 1'b1;
        val  = '0;
        case (w[6:0])
            7'b0110011: val = alu_model(w[14:12], w[30], a, model_regs[w[24:20]]);
            7'b0010011: val = alu_model(w[14:12], w[30] && (w[14:12] == 3'd5), a,
                                        {{20{w[31]}}, w[31:20]});
            7'b0110111: val = {w[31:12], 12'b0};
            default:    kept = 1'b0;
        endcase
        if (kept) begin
            exp_rd.push_back(rd);
            exp_data.push_back(val);
            n_kept++;
            // x0 results still leave on the port
            if (rd != 5'd0) begin
                model_regs[rd] = val;
            end
        end
    endtask

    // Called between falling and rising edge, when all outputs are settled
    task automatic observe();
        if (held_valid) begin
            check_value("held result_valid", 32'd1, 32'(result_valid));
            check_value("held result_rd", 32'(held_rd), 32'(result_rd));
            check_value("held result_data", held_data, result_data);
        end
        if (result_valid && !result_ready) begin
            check_value("instr_ready during stall", 32'd0, 32'(instr_ready));
        end
        held_valid = result_valid && !result_ready;
        held_rd    = result_rd;
        held_data  = result_data;
        if (result_valid && result_ready) begin
            if (exp_rd.size() == 0) begin
                stop_with_error("A result appeared with no accepted instruction to match it");
            end else begin
                check_value($sformatf("result %0d rd", n_results),
                            32'(exp_rd[0]), 32'(result_rd));
                check_value($sformatf("result %0d data", n_results), exp_data[0], result_data);
                void'(exp_rd.pop_front());
                void'(exp_data.pop_front());
                n_results++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        seed         = 4876;
        rst_n        = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        result_ready = 1'b0;
        n_kept       = 0;
        n_results    = 0;
        n_sent       = 0;
        drain_cycles = 0;
        held_valid   = 1'b0;
        held_rd      = '0;
        held_data    = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_value("result_valid after reset", 32'd0, 32'(result_valid));
        check_value("instr_ready after reset", 32'd1, 32'(instr_ready));

        // Random stream with random flow control on both ports
        next_word = gen_instr();
        while (n_sent < NUM_INSTR) begin
            @(negedge clk);
            instr_valid  = (rand32() % 32'd4) != 32'd0;
            instr        = next_word;
            result_ready = (rand32() % 32'd10) < 32'd7;
            #1;
            observe();
            if (instr_valid && instr_ready) begin
                model_accept(instr);
                n_sent++;
                next_word = gen_instr();
            end
        end

        // Drain whatever is still in flight
        while (exp_rd.size() != 0 && drain_cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            instr_valid  = 1'b0;
            result_ready = (rand32() % 32'd10) < 32'd7;
            #1;
            observe();
            drain_cycles++;
        end

        repeat (4) begin
            @(negedge clk);
            result_ready = 1'b1;
            #1;
            observe();
            check_value("result_valid when idle", 32'd0, 32'(result_valid));
        end

        check_value("result count", 32'(n_kept), 32'(n_results));
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== int_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_core #(
    parameter int NUM_REGS = 32
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      instr_valid,
    output logic                      instr_ready,
    input  logic [31:0]               instr,
    output logic                      result_valid,
    input  logic                      result_ready,
    output logic [4:0]                result_rd,
    output logic [core_pkg::XLEN-1:0] result_data
);

    localparam int AW = $clog2(NUM_REGS);

    logic                      stall;

    // Decode to execute
    logic                      dec_valid;
    core_pkg::alu_op_e         dec_op;
    logic [AW-1:0]             dec_rs1;
    logic [AW-1:0]             dec_rs2;
    logic                      dec_use_imm;
    logic [core_pkg::XLEN-1:0] dec_imm;
    logic [AW-1:0]             dec_rd;

    // Execute to result
    logic                      ex_valid;
    logic [AW-1:0]             ex_rd;
    logic [core_pkg::XLEN-1:0] ex_data;

    // Register file ports and bypass
    logic [AW-1:0]             rd_addr_a;
    logic [AW-1:0]             rd_addr_b;
    logic [core_pkg::XLEN-1:0] rd_data_a;
    logic [core_pkg::XLEN-1:0] rd_data_b;
    logic                      fwd_valid;
    logic [AW-1:0]             fwd_rd;
    logic [core_pkg::XLEN-1:0] fwd_data;
    logic                      wr_en;
    logic [AW-1:0]             wr_addr;
    logic [core_pkg::XLEN-1:0] wr_data;

    // Single pipeline-wide stall
    assign stall = result_valid && !result_ready;

    int_decode #(.NUM_REGS(NUM_REGS)) int_decode_i (
        .clk(clk), .rst_n(rst_n), .stall(stall),
        .instr_valid(instr_valid), .instr(instr), .instr_ready(instr_ready),
        .dec_valid(dec_valid), .dec_op(dec_op), .dec_rs1(dec_rs1), .dec_rs2(dec_rs2),
        .dec_use_imm(dec_use_imm), .dec_imm(dec_imm), .dec_rd(dec_rd)
    );

    int_execute #(.NUM_REGS(NUM_REGS)) int_execute_i (
        .clk(clk), .rst_n(rst_n), .stall(stall),
        .dec_valid(dec_valid), .dec_op(dec_op), .dec_rs1(dec_rs1), .dec_rs2(dec_rs2),
        .dec_use_imm(dec_use_imm), .dec_imm(dec_imm), .dec_rd(dec_rd),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .fwd_valid(fwd_valid), .fwd_rd(fwd_rd), .fwd_data(fwd_data),
        .ex_valid(ex_valid), .ex_rd(ex_rd), .ex_data(ex_data)
    );

    int_result #(.NUM_REGS(NUM_REGS)) int_result_i (
        .clk(clk), .rst_n(rst_n), .stall(stall),
        .ex_valid(ex_valid), .ex_rd(ex_rd), .ex_data(ex_data),
        .result_ready(result_ready), .result_valid(result_valid),
        .result_rd(result_rd), .result_data(result_data),
        .fwd_valid(fwd_valid), .fwd_rd(fwd_rd), .fwd_data(fwd_data),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    reg_file #(.NUM_REGS(NUM_REGS)) reg_file_i (
        .clk(clk), .rst_n(rst_n),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b)
    );

endmodule

`default_nettype wire

// ==== int_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_result #(
    parameter int NUM_REGS = 32
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        stall,
    input  logic                        ex_valid,
    input  logic [$clog2(NUM_REGS)-1:0] ex_rd,
    input  logic [core_pkg::XLEN-1:0]   ex_data,
    input  logic                        result_ready,
    output logic                        result_valid,
    output logic [4:0]                  result_rd,
    output logic [core_pkg::XLEN-1:0]   result_data,
    output logic                        fwd_valid,
    output logic [$clog2(NUM_REGS)-1:0] fwd_rd,
    output logic [core_pkg::XLEN-1:0]   fwd_data,
    output logic                        wr_en,
    output logic [$clog2(NUM_REGS)-1:0] wr_addr,
    output logic [core_pkg::XLEN-1:0]   wr_data
);

    // Result port shows the execute register directly
    assign result_valid = ex_valid;
    assign result_rd    = 5'(ex_rd);
    assign result_data  = ex_data;

    // Bypass source for execute
    assign fwd_valid = ex_valid;
    assign fwd_rd    = ex_rd;
    assign fwd_data  = ex_data;

    // Write back only when the result leaves, never to x0
    assign wr_en   = ex_valid && result_ready && (ex_rd != '0);
    assign wr_addr = ex_rd;
    assign wr_data = ex_data;

    // Stall must freeze the execute register behind this port
    a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(result_valid) && $stable(result_rd) && $stable(result_data));

endmodule

`default_nettype wire

// ==== int_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_execute #(
    parameter int NUM_REGS = 32
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        stall,
    input  logic                        dec_valid,
    input  core_pkg::alu_op_e           dec_op,
    input  logic [$clog2(NUM_REGS)-1:0] dec_rs1,
    input  logic [$clog2(NUM_REGS)-1:0] dec_rs2,
    input  logic                        dec_use_imm,
    input  logic [core_pkg::XLEN-1:0]   dec_imm,
    input  logic [$clog2(NUM_REGS)-1:0] dec_rd,
    output logic [$clog2(NUM_REGS)-1:0] rd_addr_a,
    output logic [$clog2(NUM_REGS)-1:0] rd_addr_b,
    input  logic [core_pkg::XLEN-1:0]   rd_data_a,
    input  logic [core_pkg::XLEN-1:0]   rd_data_b,
    input  logic                        fwd_valid,
    input  logic [$clog2(NUM_REGS)-1:0] fwd_rd,
    input  logic [core_pkg::XLEN-1:0]   fwd_data,
    output logic                        ex_valid,
    output logic [$clog2(NUM_REGS)-1:0] ex_rd,
    output logic [core_pkg::XLEN-1:0]   ex_data
);

    logic                      fwd_hit_a;
    logic                      fwd_hit_b;
    logic [core_pkg::XLEN-1:0] src_a;
    logic [core_pkg::XLEN-1:0] src_b;
    logic [core_pkg::XLEN-1:0] opnd_b;
    logic [4:0]                shamt;
    logic [core_pkg::XLEN-1:0] alu_res;

    assign rd_addr_a = dec_rs1;
    assign rd_addr_b = dec_rs2;

    ////////////////////////////////////////////////////////////
    // Operand select
    ////////////////////////////////////////////////////////////

    // Result stage has not written back yet, so bypass it
    assign fwd_hit_a = fwd_valid && (fwd_rd != '0) && (fwd_rd == dec_rs1);
    assign fwd_hit_b = fwd_valid && (fwd_rd != '0) && (fwd_rd == dec_rs2);

    assign src_a  = fwd_hit_a ? fwd_data : rd_data_a;
    assign src_b  = fwd_hit_b ? fwd_data : rd_data_b;
    assign opnd_b = dec_use_imm ? dec_imm : src_b;
    assign shamt  = opnd_b[4:0];

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (dec_op)
            core_pkg::ALU_ADD:  alu_res = src_a + opnd_b;
            core_pkg::ALU_SUB:  alu_res = src_a - opnd_b;
            core_pkg::ALU_SLL:  alu_res = src_a << shamt;
            core_pkg::ALU_SLT:  alu_res = {31'b0, $signed(src_a) < $signed(opnd_b)};
            core_pkg::ALU_SLTU: alu_res = {31'b0, src_a < opnd_b};
            core_pkg::ALU_XOR:  alu_res = src_a ^ opnd_b;
            core_pkg::ALU_SRL:  alu_res = src_a >> shamt;
            core_pkg::ALU_SRA:  alu_res = $unsigned($signed(src_a) >>> shamt);
            core_pkg::ALU_OR:   alu_res = src_a | opnd_b;
            core_pkg::ALU_AND:  alu_res = src_a & opnd_b;
            default:            alu_res = opnd_b;
        endcase
    end

    // Output register, also serves as the result stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (!stall) begin
            ex_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_rd   <= dec_rd;
            ex_data <= alu_res;
        end
    end

    a_idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |=> !ex_valid);

endmodule

`default_nettype wire

// ==== int_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_decode #(
    parameter int NUM_REGS = 32
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        stall,
    input  logic                        instr_valid,
    input  logic [31:0]                 instr,
    output logic                        instr_ready,
    output logic                        dec_valid,
    output core_pkg::alu_op_e           dec_op,
    output logic [$clog2(NUM_REGS)-1:0] dec_rs1,
    output logic [$clog2(NUM_REGS)-1:0] dec_rs2,
    output logic                        dec_use_imm,
    output logic [core_pkg::XLEN-1:0]   dec_imm,
    output logic [$clog2(NUM_REGS)-1:0] dec_rd
);

    localparam int AW = $clog2(NUM_REGS);

    logic                            word_valid;
    core_pkg::instr_u                word_q;
    logic                            known;
    logic                            alt;
    core_pkg::alu_op_e               op;
    logic                            use_imm;
    logic [core_pkg::XLEN-1:0]       imm;
    logic [4:0]                      rs1;
    logic [4:0]                      rs2;

    // RV32E has fewer architectural registers
    function automatic logic reg_ok(input logic [4:0] r);
        return (r < NUM_REGS);
    endfunction

    function automatic core_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic sub_sra);
        case (f3)
            3'b000:  return sub_sra ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b001:  return core_pkg::ALU_SLL;
            3'b010:  return core_pkg::ALU_SLT;
            3'b011:  return core_pkg::ALU_SLTU;
            3'b100:  return core_pkg::ALU_XOR;
            3'b101:  return sub_sra ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110:  return core_pkg::ALU_OR;
            default: return core_pkg::ALU_AND;
        endcase
    endfunction

    assign instr_ready = !stall;

    ////////////////////////////////////////////////////////////
    // Field decode of the held word
    ////////////////////////////////////////////////////////////

    always_comb begin
        alt     = (word_q.r.funct7 == 7'b0100000);
        known   = 1'b0;
        op      = alu_sel(word_q.r.funct3, 1'b0);
        use_imm = 1'b1;
        imm     = {{20{word_q.i.imm12[11]}}, word_q.i.imm12};
        rs1     = word_q.i.rs1;
        rs2     = '0;
        case (word_q.r.opcode)
            core_pkg::OPC_OP: begin
                use_imm = 1'b0;
                rs2     = word_q.r.rs2;
                op      = alu_sel(word_q.r.funct3, alt);
                // Only ADD/SUB and SRL/SRA have an alternate funct7
                known   = (word_q.r.funct7 == 7'b0) ||
                          (alt && (word_q.r.funct3 == 3'b000 || word_q.r.funct3 == 3'b101));
                known   = known && reg_ok(rs1) && reg_ok(rs2) && reg_ok(word_q.r.rd);
            end
            core_pkg::OPC_OP_IMM: begin
                op = alu_sel(word_q.i.funct3, alt && word_q.i.funct3 == 3'b101);
                case (word_q.i.funct3)
                    3'b001:  known = (word_q.r.funct7 == 7'b0);
                    3'b101:  known = (word_q.r.funct7 == 7'b0) || alt;
                    default: known = 1'b1;
                endcase
                known = known && reg_ok(rs1) && reg_ok(word_q.i.rd);
            end
            core_pkg::OPC_LUI: begin
                op    = core_pkg::ALU_PASS_B;
                rs1   = '0;
                imm   = {word_q.i.imm12, word_q.i.rs1, word_q.i.funct3, 12'b0};
                known = reg_ok(word_q.i.rd);
            end
            default: known = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Word register and decoded-operation register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_valid <= 1'b0;
            dec_valid  <= 1'b0;
            dec_op     <= core_pkg::ALU_ADD;
        end else if (!stall) begin
            word_valid <= instr_valid;
            // Unsupported words just vanish here
            dec_valid  <= word_valid && known;
            dec_op     <= op;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            word_q      <= instr;
            dec_rs1     <= rs1[AW-1:0];
            dec_rs2     <= rs2[AW-1:0];
            dec_use_imm <= use_imm;
            dec_imm     <= imm;
            dec_rd      <= word_q.r.rd[AW-1:0];
        end
    end

    a_op_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(dec_op));

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
    parameter int NUM_REGS = 32
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        wr_en,
    input  logic [$clog2(NUM_REGS)-1:0] wr_addr,
    input  logic [31:0]                 wr_data,
    input  logic [$clog2(NUM_REGS)-1:0] rd_addr_a,
    input  logic [$clog2(NUM_REGS)-1:0] rd_addr_b,
    output logic [31:0]                 rd_data_a,
    output logic [31:0]                 rd_data_b
);

    logic [31:0] regs [NUM_REGS];

    // Synchronous write port
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Combinational reads, x0 hardwired to zero
    assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

    // Writeback logic must already filter rd 0
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_en && wr_addr == '0));

endmodule

`default_nettype wire

// ==== core_pkg.sv ====
`default_nettype none

package core_pkg;

    // Architecture data width, fixed by RV32I
    localparam int XLEN = 32;

    ////////////////////////////////////////////////////////////
    // Major opcodes handled by the pipeline
    ////////////////////////////////////////////////////////////

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    ////////////////////////////////////////////////////////////
    // ALU operations
    ////////////////////////////////////////////////////////////

    // PASS_B forwards operand B untouched, used by LUI
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    ////////////////////////////////////////////////////////////
    // Instruction word views
    ////////////////////////////////////////////////////////////

    // R-type layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fields_t;

    // I-type layout, imm12 overlays funct7 and rs2
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fields_t;

    // Same 32-bit word seen either way
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_u;

endpackage

`default_nettype wire
